/* include/seg_bridge_defs.svh */
// widths, depths and thresholds of the segmented stream bridge, included by every design file
`ifndef SEG_BRIDGE_DEFS_SVH
`define SEG_BRIDGE_DEFS_SVH

// ********************************************************************
// channel and segment geometry
// ********************************************************************
`define SB_NUM_CH       2
`define SB_SEGS_PER_CH  2
`define SB_SEG_CH       (`SB_NUM_CH * `SB_SEGS_PER_CH)   // output segments in total
`define SB_SEG_DW       32
`define SB_SEG_KW       4
`define SB_MTY_W        2

// ingress beat fields
`define SB_ING_DW       64
`define SB_ING_KW       8
`define SB_ING_TID_W    6
`define SB_ING_TDEST_W  7

// sideband packed inside id and dest
`define SB_EGR_TID_W    3
`define SB_ID_W         2

// ********************************************************************
// buffering
// ********************************************************************
`define SB_FIFO_DEPTH   16
`define SB_MIN_FILL     4       // beats each channel holds before the drain starts
`define SB_FULL_MARGIN  4       // covers pops still in flight
`define SB_CNT_W        ($clog2(`SB_FIFO_DEPTH) + 1)

// {data, keep, tid, tdest}
`define SB_ING_FIFO_W   (`SB_ING_DW + `SB_ING_KW + `SB_ING_TID_W + `SB_ING_TDEST_W)

// {data, mty per segment, ena per segment, tid, tdest}
`define SB_EGR_FIFO_W   (`SB_ING_DW + `SB_SEGS_PER_CH * (`SB_MTY_W + 1) + \
                         `SB_ING_TID_W + `SB_ING_TDEST_W)

`endif

/* logic/seg_bridge_pkg.sv */
// shared segment, id and drain state types, taken into each module by wildcard import
`default_nettype none

`include "seg_bridge_defs.svh"

package seg_bridge_pkg;

    typedef logic [`SB_SEG_DW-1:0]    seg_data_t;   // one output segment
    typedef logic [`SB_MTY_W-1:0]     seg_mty_t;    // empty bytes at the top of a segment
    typedef logic [`SB_ID_W-1:0]      xfer_id_t;
    typedef logic [`SB_EGR_TID_W-1:0] egr_tid_t;

    // start-up sequence of the lockstep drain
    typedef enum logic [1:0] {
        FILL,    // waiting for every channel to reach min fill
        ARM,     // one cycle of settle
        DRAIN    // lockstep pops allowed
    } drain_state_e;

endpackage

`default_nettype wire

/* logic/sync_fifo.sv */
// first-word-fall-through synchronous FIFO with fill count and near-full flag, any width
`timescale 1ns/100ps
`default_nettype none

`include "seg_bridge_defs.svh"

module sync_fifo #(
    parameter int width = 8,
    parameter int depth = 16            // power of two
) (
    input  logic                   aclk,
    input  logic                   local_rstn,
    input  logic                   wr_en,
    input  logic [width-1:0]       wr_data,
    input  logic                   rd_en,
    output logic                   full,
    output logic                   rd_valid,
    output logic [width-1:0]       rd_data,
    output logic [$clog2(depth):0] count,
    output logic                   near_full
);

    localparam int aw       = $clog2(depth);
    localparam int nf_level = depth - `SB_FULL_MARGIN;

    logic [width-1:0] mem [depth];
    logic [aw-1:0]    wr_ptr;
    logic [aw-1:0]    rd_ptr;
    logic [aw:0]      count_nxt;
    logic             do_wr;
    logic             do_rd;

    assign do_wr    = wr_en & ~full;        // write when full is dropped
    assign do_rd    = rd_en & rd_valid;     // read when empty is dropped
    assign rd_valid = (count != '0);
    assign rd_data  = rd_valid ? mem[rd_ptr] : '0;

    always_comb begin
        count_nxt = count;
        if (do_wr && !do_rd)
            count_nxt = count + 1'b1;
        else if (do_rd && !do_wr)
            count_nxt = count - 1'b1;
    end

    always_ff @(posedge aclk) begin
        if (!local_rstn) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            full      <= 1'b1;          // no writes until the cycle after reset
            near_full <= 1'b0;
        end else begin
            if (do_wr)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_rd)
                rd_ptr <= rd_ptr + 1'b1;
            count     <= count_nxt;
            full      <= (count_nxt == depth);
            near_full <= (count_nxt >= nf_level);
        end
    end

    always_ff @(posedge aclk) begin
        if (do_wr)
            mem[wr_ptr] <= wr_data;
    end

endmodule

`default_nettype wire

/* logic/drain_ctrl.sv */
// start-up fill threshold and lockstep pop for all ingress channels, held off by egress room
`timescale 1ns/100ps
`default_nettype none

`include "seg_bridge_defs.svh"

module drain_ctrl
    import seg_bridge_pkg::*;
(
    input  logic                                  aclk,
    input  logic                                  local_rstn,
    input  logic [`SB_NUM_CH-1:0]                 ing_valid,
    input  logic [`SB_NUM_CH-1:0][`SB_CNT_W-1:0]  ing_count,
    input  logic [`SB_NUM_CH-1:0]                 egr_near_full,
    output logic                                  pop
);

    drain_state_e state;
    drain_state_e state_nxt;
    logic         all_min_fill;
    logic         min_fill_q;
    logic         egr_room_q;

    always_comb begin
        all_min_fill = 1'b1;
        for (int ch = 0; ch < `SB_NUM_CH; ch++) begin
            if (ing_count[ch] < `SB_MIN_FILL)
                all_min_fill = 1'b0;
        end
    end

    // ********************************************************************
    // start-up FSM
    // ********************************************************************
    always_comb begin
        state_nxt = state;
        case (state)
            FILL:    if (min_fill_q) state_nxt = ARM;
            ARM:     state_nxt = DRAIN;
            DRAIN:   state_nxt = DRAIN;
            default: state_nxt = FILL;
        endcase
        if (ing_valid == '0)
            state_nxt = FILL;               // everything drained, realign
    end

    always_ff @(posedge aclk) begin
        if (!local_rstn) begin
            state      <= FILL;
            min_fill_q <= 1'b0;
            egr_room_q <= 1'b0;
        end else begin
            state      <= state_nxt;
            min_fill_q <= all_min_fill;
            egr_room_q <= ~|egr_near_full;  // one near-full stalls every channel
        end
    end

    // same strobe to every channel keeps beats paired
    assign pop = (state == DRAIN) && (&ing_valid) && egr_room_q;

endmodule

`default_nettype wire

/* logic/seg_convert.sv */
// keep-to-empty and enable conversion of one channel, registered as the egress FIFO write
`timescale 1ns/100ps
`default_nettype none

`include "seg_bridge_defs.svh"

module seg_convert
    import seg_bridge_pkg::*;
(
    input  logic                         aclk,
    input  logic                         local_rstn,
    input  logic                         pop,
    input  logic [`SB_ING_DW-1:0]        in_data,
    input  logic [`SB_ING_KW-1:0]        in_keep,
    input  logic [`SB_ING_TID_W-1:0]     in_tid,
    input  logic [`SB_ING_TDEST_W-1:0]   in_tdest,
    output logic                         egr_wr_en,
    output logic [`SB_EGR_FIFO_W-1:0]    egr_wr_data
);

    seg_mty_t [`SB_SEGS_PER_CH-1:0] seg_mty;
    logic [`SB_SEGS_PER_CH-1:0]     seg_ena;

    // zero keep bits above the highest set one
    function automatic seg_mty_t keep_to_mty(input logic [`SB_SEG_KW-1:0] keep);
        seg_mty_t mty;
        logic     seen;
        mty  = '0;
        seen = 1'b0;
        for (int i = `SB_SEG_KW-1; i >= 0; i--) begin
            if (keep[i])
                seen = 1'b1;
            else if (!seen)
                mty = mty + 1'b1;
        end
        return mty;
    endfunction

    always_comb begin
        for (int s = 0; s < `SB_SEGS_PER_CH; s++) begin
            seg_mty[s] = keep_to_mty(in_keep[s*`SB_SEG_KW +: `SB_SEG_KW]);
            seg_ena[s] = in_keep[s*`SB_SEG_KW];     // keep is contiguous from bit 0
        end
    end

    always_ff @(posedge aclk) begin
        if (!local_rstn)
            egr_wr_en <= 1'b0;
        else
            egr_wr_en <= pop;
    end

    always_ff @(posedge aclk) begin
        if (pop)
            egr_wr_data <= {in_data, seg_mty, seg_ena, in_tid, in_tdest};
    end

endmodule

`default_nettype wire

/* logic/egress_align_check.sv */
// unpacks the egress FIFO heads into segment outputs and flags misaligned channels
`timescale 1ns/100ps
`default_nettype none

`include "seg_bridge_defs.svh"

module egress_align_check
    import seg_bridge_pkg::*;
(
    input  logic                                      aclk,
    input  logic                                      local_rstn,
    input  logic [`SB_NUM_CH-1:0]                     egr_valid,
    input  logic [`SB_NUM_CH-1:0][`SB_EGR_FIFO_W-1:0] head_data,
    input  logic [`SB_NUM_CH-1:0]                     egr_ready,
    output seg_data_t [`SB_SEG_CH-1:0]                egr_tdata,
    output logic [`SB_SEG_CH-1:0]                     egr_tuser_ena,
    output logic [`SB_SEG_CH-1:0]                     egr_tuser_sop,
    output logic [`SB_SEG_CH-1:0]                     egr_tuser_eop,
    output logic [`SB_SEG_CH-1:0]                     egr_tuser_err,
    output seg_mty_t [`SB_SEG_CH-1:0]                 egr_tuser_mty,
    output egr_tid_t                                  egr_tid,
    output logic [`SB_NUM_CH-1:0]                     egr_rd_en,
    output logic                                      err_alignment
);

    logic [`SB_NUM_CH-1:0][`SB_ING_DW-1:0]           h_data;
    seg_mty_t [`SB_NUM_CH-1:0][`SB_SEGS_PER_CH-1:0]  h_mty;
    logic [`SB_NUM_CH-1:0][`SB_SEGS_PER_CH-1:0]      h_ena;
    logic [`SB_NUM_CH-1:0][`SB_SEGS_PER_CH-1:0]      h_sop;
    logic [`SB_NUM_CH-1:0][`SB_SEGS_PER_CH-1:0]      h_eop;
    logic [`SB_NUM_CH-1:0][`SB_SEGS_PER_CH-1:0]      h_err;
    xfer_id_t [`SB_NUM_CH-1:0]                       h_id;
    xfer_id_t [`SB_NUM_CH-1:0]                       h_alt_id;
    egr_tid_t [`SB_NUM_CH-1:0]                       h_tid;
    logic id_mis;
    logic tid_mis;
    logic alt_mis;
    logic id_mis_q;
    logic tid_mis_q;
    logic alt_mis_q;

    // tid = {id, sop, eop}, tdest = {alt id, egress tid, err}
    for (genvar ch = 0; ch < `SB_NUM_CH; ch++) begin : gen_unpack
        assign {h_data[ch], h_mty[ch], h_ena[ch], h_id[ch], h_sop[ch], h_eop[ch],
                h_alt_id[ch], h_tid[ch], h_err[ch]} = head_data[ch];
    end

    always_comb begin
        for (int ch = 0; ch < `SB_NUM_CH; ch++) begin
            for (int s = 0; s < `SB_SEGS_PER_CH; s++) begin
                egr_tdata[ch*`SB_SEGS_PER_CH+s]     = h_data[ch][s*`SB_SEG_DW +: `SB_SEG_DW];
                egr_tuser_mty[ch*`SB_SEGS_PER_CH+s] = h_mty[ch][s];
                egr_tuser_ena[ch*`SB_SEGS_PER_CH+s] = h_ena[ch][s] & egr_valid[ch];
                egr_tuser_sop[ch*`SB_SEGS_PER_CH+s] = h_sop[ch][s];
                egr_tuser_eop[ch*`SB_SEGS_PER_CH+s] = h_eop[ch][s];
                egr_tuser_err[ch*`SB_SEGS_PER_CH+s] = h_err[ch][s];
            end
        end
    end

    assign egr_tid   = h_tid[0];               // channel 0 speaks for the group
    assign egr_rd_en = egr_valid & egr_ready;

    // ********************************************************************
    // alignment check, heads compared whether valid or not
    // ********************************************************************
    always_comb begin
        id_mis  = 1'b0;
        tid_mis = 1'b0;
        alt_mis = 1'b0;
        for (int ch = 0; ch < `SB_NUM_CH; ch++) begin
            if (h_id[ch] != h_id[0])
                id_mis = 1'b1;
            if (h_tid[ch] != h_tid[0])
                tid_mis = 1'b1;
            if (h_alt_id[ch] != h_id[ch])
                alt_mis = 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (!local_rstn) begin
            id_mis_q      <= 1'b0;
            tid_mis_q     <= 1'b0;
            alt_mis_q     <= 1'b0;
            err_alignment <= 1'b0;
        end else begin
            id_mis_q      <= id_mis;
            tid_mis_q     <= tid_mis;
            alt_mis_q     <= alt_mis;
            err_alignment <= id_mis_q | tid_mis_q | alt_mis_q;   // second stage
        end
    end

endmodule

`default_nettype wire

/* logic/seg_bridge_top.sv */
// bridge top: per-channel ingress FIFOs, converters and egress FIFOs under one lockstep drain
`timescale 1ns/100ps
`default_nettype none

`include "seg_bridge_defs.svh"

module seg_bridge_top
    import seg_bridge_pkg::*;
(
    input  logic                                    aclk,
    input  logic                                    local_rstn,
    input  logic [`SB_NUM_CH-1:0]                   ing_tvalid,
    output logic [`SB_NUM_CH-1:0]                   ing_tready,
    input  logic [`SB_NUM_CH*`SB_ING_DW-1:0]        ing_tdata,
    input  logic [`SB_NUM_CH*`SB_ING_KW-1:0]        ing_tkeep,
    input  logic [`SB_NUM_CH*`SB_ING_TID_W-1:0]     ing_tid,
    input  logic [`SB_NUM_CH*`SB_ING_TDEST_W-1:0]   ing_tdest,
    input  logic [`SB_NUM_CH-1:0]                   egr_ready,
    output logic [`SB_NUM_CH-1:0]                   egr_valid,
    output seg_data_t [`SB_SEG_CH-1:0]              egr_tdata,
    output logic [`SB_SEG_CH-1:0]                   egr_tuser_ena,
    output logic [`SB_SEG_CH-1:0]                   egr_tuser_sop,
    output logic [`SB_SEG_CH-1:0]                   egr_tuser_eop,
    output logic [`SB_SEG_CH-1:0]                   egr_tuser_err,
    output seg_mty_t [`SB_SEG_CH-1:0]               egr_tuser_mty,
    output egr_tid_t                                egr_tid,
    output logic                                    err_alignment
);

    // field offsets in an ingress FIFO word
    localparam int tid_lsb  = `SB_ING_TDEST_W;
    localparam int keep_lsb = tid_lsb + `SB_ING_TID_W;

    logic                                         pop;            // shared by all channels
    logic [`SB_NUM_CH-1:0]                        ing_full;
    logic [`SB_NUM_CH-1:0]                        ing_valid;
    logic [`SB_NUM_CH-1:0][`SB_CNT_W-1:0]         ing_count;
    logic [`SB_NUM_CH-1:0][`SB_ING_FIFO_W-1:0]    ing_head;
    logic [`SB_NUM_CH-1:0]                        egr_wr_en;
    logic [`SB_NUM_CH-1:0][`SB_EGR_FIFO_W-1:0]    egr_wr_data;
    logic [`SB_NUM_CH-1:0]                        egr_near_full;
    logic [`SB_NUM_CH-1:0]                        egr_rd_en;
    logic [`SB_NUM_CH-1:0][`SB_EGR_FIFO_W-1:0]    head_data;

    assign ing_tready = ~ing_full;

    // ********************************************************************
    // per-channel datapath
    // ********************************************************************
    for (genvar ch = 0; ch < `SB_NUM_CH; ch++) begin : gen_ch

        sync_fifo #(.width(`SB_ING_FIFO_W), .depth(`SB_FIFO_DEPTH)) ing_fifo_i (
            .aclk       (aclk),
            .local_rstn (local_rstn),
            .wr_en      (ing_tvalid[ch] & ~ing_full[ch]),
            .wr_data    ({ing_tdata[ch*`SB_ING_DW +: `SB_ING_DW],
                          ing_tkeep[ch*`SB_ING_KW +: `SB_ING_KW],
                          ing_tid[ch*`SB_ING_TID_W +: `SB_ING_TID_W],
                          ing_tdest[ch*`SB_ING_TDEST_W +: `SB_ING_TDEST_W]}),
            .rd_en      (pop),
            .full       (ing_full[ch]),
            .rd_valid   (ing_valid[ch]),
            .rd_data    (ing_head[ch]),
            .count      (ing_count[ch]),
            .near_full  ()                  // ingress side stalls on full only
        );

        seg_convert conv_i (
            .aclk        (aclk),
            .local_rstn  (local_rstn),
            .pop         (pop),
            .in_data     (ing_head[ch][`SB_ING_FIFO_W-1 -: `SB_ING_DW]),
            .in_keep     (ing_head[ch][keep_lsb +: `SB_ING_KW]),
            .in_tid      (ing_head[ch][tid_lsb +: `SB_ING_TID_W]),
            .in_tdest    (ing_head[ch][0 +: `SB_ING_TDEST_W]),
            .egr_wr_en   (egr_wr_en[ch]),
            .egr_wr_data (egr_wr_data[ch])
        );

        sync_fifo #(.width(`SB_EGR_FIFO_W), .depth(`SB_FIFO_DEPTH)) egr_fifo_i (
            .aclk       (aclk),
            .local_rstn (local_rstn),
            .wr_en      (egr_wr_en[ch]),
            .wr_data    (egr_wr_data[ch]),
            .rd_en      (egr_rd_en[ch]),
            .full       (),                 // margin keeps writes away from full
            .rd_valid   (egr_valid[ch]),
            .rd_data    (head_data[ch]),
            .count      (),
            .near_full  (egr_near_full[ch])
        );
    end

    // ********************************************************************
    // drain control and egress side
    // ********************************************************************
    drain_ctrl drain_i (
        .aclk          (aclk),
        .local_rstn    (local_rstn),
        .ing_valid     (ing_valid),
        .ing_count     (ing_count),
        .egr_near_full (egr_near_full),
        .pop           (pop)
    );

    egress_align_check align_i (
        .aclk          (aclk),
        .local_rstn    (local_rstn),
        .egr_valid     (egr_valid),
        .head_data     (head_data),
        .egr_ready     (egr_ready),
        .egr_tdata     (egr_tdata),
        .egr_tuser_ena (egr_tuser_ena),
        .egr_tuser_sop (egr_tuser_sop),
        .egr_tuser_eop (egr_tuser_eop),
        .egr_tuser_err (egr_tuser_err),
        .egr_tuser_mty (egr_tuser_mty),
        .egr_tid       (egr_tid),
        .egr_rd_en     (egr_rd_en),
        .err_alignment (err_alignment)
    );

endmodule

`default_nettype wire

/* tests/seg_bridge_chk.sv */
// concurrent assertions bound into the bridge top, compiled with the testbench through the file list
`timescale 1ns/100ps
`default_nettype none

`include "seg_bridge_defs.svh"

module seg_bridge_chk (
    input  logic                                 aclk,
    input  logic                                 local_rstn,
    input  logic                                 pop,
    input  logic [`SB_NUM_CH-1:0][`SB_CNT_W-1:0] ing_count,
    input  logic [`SB_NUM_CH-1:0]                ing_tready,
    input  logic [`SB_NUM_CH-1:0]                egr_valid
);

    for (genvar ch = 0; ch < `SB_NUM_CH; ch++) begin : gen_ch

        // lockstep pop needs a stored beat in every ingress FIFO
        pop_needs_data: assert property (@(posedge aclk) disable iff (!local_rstn)
            pop |-> (ing_count[ch] != '0))
            else $error("pop issued while ingress FIFO %0d was empty", ch);

        tready_on_full: assert property (@(posedge aclk) disable iff (!local_rstn)
            (ing_count[ch] == `SB_FIFO_DEPTH) |-> !ing_tready[ch])
            else $error("ing_tready[%0d] high while its ingress FIFO was full", ch);
    end

    // first two cycles out of reset
    quiet_after_reset: assert property (@(posedge aclk)
        (local_rstn && !($past(local_rstn) && $past(local_rstn, 2))) |-> (egr_valid == '0))
        else $error("egr_valid high within two cycles of reset release");

endmodule

bind seg_bridge_top seg_bridge_chk chk_i (
    .aclk       (aclk),
    .local_rstn (local_rstn),
    .pop        (pop),
    .ing_count  (ing_count),
    .ing_tready (ing_tready),
    .egr_valid  (egr_valid)
);

`default_nettype wire

/* tests/seg_bridge_mon.sv */
// egress scoreboard of the testbench, compares every beat that leaves against its channel queue
`timescale 1ns/100ps
`default_nettype none

`include "seg_bridge_defs.svh"

module seg_bridge_mon
    import seg_bridge_pkg::*;
(
    input  logic                     aclk,
    input  logic                     local_rstn,
    input  logic [`SB_NUM_CH-1:0]    ing_tready,
    input  logic [`SB_NUM_CH-1:0]    egr_valid,
    input  logic [`SB_NUM_CH-1:0]    egr_ready,
    input  seg_data_t [`SB_SEG_CH-1:0] egr_tdata,
    input  logic [`SB_SEG_CH-1:0]    egr_tuser_ena,
    input  logic [`SB_SEG_CH-1:0]    egr_tuser_sop,
    input  logic [`SB_SEG_CH-1:0]    egr_tuser_eop,
    input  logic [`SB_SEG_CH-1:0]    egr_tuser_err,
    input  seg_mty_t [`SB_SEG_CH-1:0] egr_tuser_mty,
    input  egr_tid_t                 egr_tid,
    input  logic                     err_alignment
);

    // {data, mty s1 s0, ena, sop, eop, err, egress tid}
    localparam int exp_w = `SB_ING_DW + `SB_SEGS_PER_CH * (`SB_MTY_W + 4) + `SB_EGR_TID_W;

    logic [exp_w-1:0] exp_q0 [$];
    logic [exp_w-1:0] exp_q1 [$];
    int   beat_errors  = 0;     // found by the sampling process
    int   flag_errors  = 0;     // found by checks the stimulus asks for
    int   beats        = 0;
    int   tests        = 0;
    int   beats_mark   = 0;
    int   errors_mark  = 0;
    int   stall_cycles = 0;
    int   stall_base   = 0;
    logic idle_check   = 1'b0;  // egr_valid must stay low
    logic quiet_check  = 1'b0;  // err_alignment must stay low

    function automatic int pending();
        return exp_q0.size() + exp_q1.size();
    endfunction

    function automatic int total_errors();
        return beat_errors + flag_errors;
    endfunction

    task automatic push_expected(input int ch, input logic [exp_w-1:0] word);
        if (ch == 0)
            exp_q0.push_back(word);
        else
            exp_q1.push_back(word);
    endtask

    task automatic compare(input string name, input int idx, input logic [63:0] exp_v,
                           input logic [63:0] act_v);
        if (exp_v !== act_v) begin
            $display("** Error %s[%0d] expected %0h actual %0h", name, idx, exp_v, act_v);
            beat_errors++;
        end
    endtask

    task automatic check_beat(input int ch);
        logic [exp_w-1:0] exp_word;
        int               o;
        if ((ch == 0 && exp_q0.size() == 0) || (ch == 1 && exp_q1.size() == 0)) begin
            $display("beat left channel %0d with no expected beat queued", ch);
            beat_errors++;
            return;
        end
        if (ch == 0)
            exp_word = exp_q0.pop_front();
        else
            exp_word = exp_q1.pop_front();
        beats++;
        for (int s = 0; s < `SB_SEGS_PER_CH; s++) begin
            o = ch * `SB_SEGS_PER_CH + s;
            compare("egr_tdata", o, 64'(exp_word[15 + s*32 +: 32]), 64'(egr_tdata[o]));
            compare("egr_tuser_mty", o, 64'(exp_word[11 + s*2 +: 2]), 64'(egr_tuser_mty[o]));
            compare("egr_tuser_ena", o, 64'(exp_word[9 + s]), 64'(egr_tuser_ena[o]));
            compare("egr_tuser_sop", o, 64'(exp_word[7 + s]), 64'(egr_tuser_sop[o]));
            compare("egr_tuser_eop", o, 64'(exp_word[5 + s]), 64'(egr_tuser_eop[o]));
            compare("egr_tuser_err", o, 64'(exp_word[3 + s]), 64'(egr_tuser_err[o]));
        end
        if (ch == 0)
            compare("egr_tid", 0, 64'(exp_word[2:0]), 64'(egr_tid));   // ch 0 head only
    endtask

    // outputs settle half a cycle after the edge
    always @(negedge aclk) begin
        if (local_rstn) begin
            for (int ch = 0; ch < `SB_NUM_CH; ch++) begin
                if (egr_valid[ch] && egr_ready[ch])
                    check_beat(ch);
            end
            if (idle_check && egr_valid != '0) begin
                $display("egr_valid rose before channel 1 reached the start threshold");
                beat_errors++;
            end
            if (quiet_check && err_alignment) begin
                $display("** Error err_alignment expected 0 actual 1");
                beat_errors++;
            end
            if (!ing_tready[0])
                stall_cycles++;
        end
    end

    task automatic check_err(input logic exp_v);
        @(negedge aclk);
        if (err_alignment !== exp_v) begin
            $display("** Error err_alignment expected %0h actual %0h", exp_v, err_alignment);
            flag_errors++;
        end
    endtask

    task automatic mark_stall();
        stall_base = stall_cycles;
    endtask

    task automatic check_stall();
        if (stall_cycles == stall_base) begin
            $display("ing_tready on channel 0 never fell while egress was held");
            flag_errors++;
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %0d %s: %0d beats checked, %0d errors", tests, name,
                 beats - beats_mark, total_errors() - errors_mark);
        beats_mark  = beats;
        errors_mark = total_errors();
    endtask

endmodule

`default_nettype wire

/* tests/seg_bridge_tb.sv */
// top module of the bridge simulation, drives both ingress channels through five tests
`timescale 1ns/100ps
`default_nettype none

`include "seg_bridge_defs.svh"

module seg_bridge_tb
    import seg_bridge_pkg::*;
();

    localparam int exp_w       = `SB_ING_DW + `SB_SEGS_PER_CH * (`SB_MTY_W + 4) + `SB_EGR_TID_W;
    localparam int total_beats = 92;                    // channel 0 beats over all tests
    localparam int cycle_limit = 40 * total_beats + 200;

    logic                                  aclk;
    logic                                  local_rstn;
    logic [`SB_NUM_CH-1:0]                 ing_tvalid;
    logic [`SB_NUM_CH-1:0]                 ing_tready;
    logic [`SB_NUM_CH*`SB_ING_DW-1:0]      ing_tdata;
    logic [`SB_NUM_CH*`SB_ING_KW-1:0]      ing_tkeep;
    logic [`SB_NUM_CH*`SB_ING_TID_W-1:0]   ing_tid;
    logic [`SB_NUM_CH*`SB_ING_TDEST_W-1:0] ing_tdest;
    logic [`SB_NUM_CH-1:0]                 egr_ready;
    logic [`SB_NUM_CH-1:0]                 egr_valid;
    seg_data_t [`SB_SEG_CH-1:0]            egr_tdata;
    logic [`SB_SEG_CH-1:0]                 egr_tuser_ena;
    logic [`SB_SEG_CH-1:0]                 egr_tuser_sop;
    logic [`SB_SEG_CH-1:0]                 egr_tuser_eop;
    logic [`SB_SEG_CH-1:0]                 egr_tuser_err;
    seg_mty_t [`SB_SEG_CH-1:0]             egr_tuser_mty;
    egr_tid_t                              egr_tid;
    logic                                  err_alignment;

    int                           seed = 15;
    int                           cycles;
    logic [`SB_ING_DW-1:0]        b_data [`SB_NUM_CH];  // next beat per channel
    logic [`SB_ING_KW-1:0]        b_keep [`SB_NUM_CH];
    logic [`SB_ING_TID_W-1:0]     b_tid  [`SB_NUM_CH];
    logic [`SB_ING_TDEST_W-1:0]   b_dest [`SB_NUM_CH];

    seg_bridge_top dut_i (.*);
    seg_bridge_mon mon_i (.*);

    // expected egress beat, laid out as the monitor unpacks it
    function automatic logic [exp_w-1:0] expected_beat(input logic [`SB_ING_DW-1:0] data,
            input logic [`SB_ING_KW-1:0] keep, input logic [`SB_ING_TID_W-1:0] tid,
            input logic [`SB_ING_TDEST_W-1:0] dest);
        logic [`SB_SEGS_PER_CH-1:0][`SB_MTY_W-1:0] mty;
        logic [`SB_SEGS_PER_CH-1:0]                ena;
        for (int s = 0; s < `SB_SEGS_PER_CH; s++) begin
            mty[s] = `SB_MTY_W'(`SB_SEG_KW - $countones(keep[s*`SB_SEG_KW +: `SB_SEG_KW]));
            ena[s] = keep[s*`SB_SEG_KW];
        end
        return {data, mty, ena, tid[3:2], tid[1:0], dest[1:0], dest[4:2]};
    endfunction

    task automatic random_beat(input int ch, input logic [`SB_ING_KW-1:0] keep);
        b_data[ch] = {$random(seed), $random(seed)};
        b_keep[ch] = keep;
        b_tid[ch]  = `SB_ING_TID_W'($random(seed));
        b_dest[ch] = `SB_ING_TDEST_W'($random(seed));
    endtask

    task automatic aligned_beat(input int ch, input xfer_id_t id, input xfer_id_t alt,
                                input egr_tid_t etid);
        random_beat(ch, 8'hff);
        b_tid[ch][5:4]  = id;
        b_dest[ch][6:5] = alt;
        b_dest[ch][4:2] = etid;
    endtask

    // called 10 ns after an edge, returns 10 ns after the accepting edge
    task automatic send(input logic [`SB_NUM_CH-1:0] mask);
        logic [`SB_NUM_CH-1:0] left;
        left = mask;
        for (int ch = 0; ch < `SB_NUM_CH; ch++) begin
            ing_tdata[ch*`SB_ING_DW +: `SB_ING_DW]          = b_data[ch];
            ing_tkeep[ch*`SB_ING_KW +: `SB_ING_KW]          = b_keep[ch];
            ing_tid[ch*`SB_ING_TID_W +: `SB_ING_TID_W]      = b_tid[ch];
            ing_tdest[ch*`SB_ING_TDEST_W +: `SB_ING_TDEST_W] = b_dest[ch];
        end
        ing_tvalid = mask;
        while (left != '0) begin
            @(negedge aclk);
            for (int ch = 0; ch < `SB_NUM_CH; ch++) begin
                if (left[ch] && ing_tready[ch]) begin
                    mon_i.push_expected(ch, expected_beat(b_data[ch], b_keep[ch],
                                                          b_tid[ch], b_dest[ch]));
                    left[ch] = 1'b0;
                end
            end
            @(posedge aclk);
            #10 ing_tvalid = left;
        end
    endtask

    task automatic drain();
        while (mon_i.pending() != 0)
            @(posedge aclk);
        repeat (4) @(posedge aclk);     // lets err_alignment follow the empty heads
        #10;
    endtask

    // one odd pair parked at the egress heads, three matched pairs behind it
    task automatic mismatch_pair(input xfer_id_t id0, input xfer_id_t alt0,
                                 input xfer_id_t id1, input xfer_id_t alt1);
        egr_ready = 2'b00;
        aligned_beat(0, id0, alt0, 3'd5);
        aligned_beat(1, id1, alt1, 3'd5);
        send(2'b11);
        for (int i = 0; i < 3; i++) begin
            aligned_beat(0, 2'(i), 2'(i), 3'd5);
            aligned_beat(1, 2'(i), 2'(i), 3'd5);
            send(2'b11);
        end
        while (egr_valid != 2'b11)
            @(negedge aclk);
        repeat (4) @(posedge aclk);
        mon_i.check_err(1'b1);
        @(posedge aclk);
        #10 egr_ready = 2'b11;
        drain();
        mon_i.check_err(1'b0);
        @(posedge aclk);
        #10;
    endtask

    initial begin
        aclk = 1'b0;
        forever #50 aclk = ~aclk;
    end

    initial begin
        cycles = 0;
        while (cycles <= cycle_limit) begin
            @(posedge aclk);
            cycles++;
        end
        $display("run stopped after %0d cycles without finishing the tests", cycle_limit);
        $display("Testbench failed");
        $finish;
    end

    // ******************************************************************
    // tests
    // ******************************************************************
    initial begin
        local_rstn = 1'b0;
        ing_tvalid = '0;
        ing_tdata  = '0;
        ing_tkeep  = '0;
        ing_tid    = '0;
        ing_tdest  = '0;
        egr_ready  = 2'b11;
        repeat (5) @(posedge aclk);
        #10 local_rstn = 1'b1;

        for (int i = 0; i < 20; i++) begin
            random_beat(0, 8'hff);
            random_beat(1, 8'hff);
            send(2'b11);
        end
        drain();
        mon_i.end_test("full keep stream");

        for (int i = 0; i < 8; i++) begin
            random_beat(0, 8'hff >> (7 - i));   // grows from one byte
            random_beat(1, 8'hff >> i);         // shrinks to one byte
            send(2'b11);
        end
        drain();
        mon_i.end_test("partial keep");

        mon_i.idle_check = 1'b1;
        for (int i = 0; i < 10; i++) begin
            random_beat(0, 8'hff);
            send(2'b01);
        end
        for (int i = 0; i < `SB_MIN_FILL - 1; i++) begin
            random_beat(1, 8'hff);
            send(2'b10);
        end
        repeat (20) @(posedge aclk);
        #10 mon_i.idle_check = 1'b0;
        for (int i = 0; i < 7; i++) begin
            random_beat(1, 8'hff);
            send(2'b10);
        end
        drain();
        mon_i.end_test("start threshold");

        mon_i.mark_stall();
        fork
            begin
                egr_ready = 2'b10;
                repeat (60) @(posedge aclk);
                #10 egr_ready = 2'b11;
            end
            for (int i = 0; i < 40; i++) begin
                random_beat(0, 8'hff);
                random_beat(1, 8'hff);
                send(2'b11);
            end
        join
        drain();
        mon_i.check_stall();
        mon_i.end_test("egress hold on channel 0");

        mon_i.quiet_check = 1'b1;
        for (int i = 0; i < 6; i++) begin
            aligned_beat(0, 2'(i), 2'(i), 3'(i));
            aligned_beat(1, 2'(i), 2'(i), 3'(i));
            send(2'b11);
        end
        drain();
        mon_i.quiet_check = 1'b0;
        mismatch_pair(2'd1, 2'd1, 2'd2, 2'd2);      // ids differ between channels
        mismatch_pair(2'd3, 2'd3, 2'd3, 2'd0);      // alternate id off on channel 1
        mon_i.end_test("alignment error");

        $display("tests %0d, beats checked %0d, errors %0d",
                 mon_i.tests, mon_i.beats, mon_i.total_errors());
        if (mon_i.total_errors() == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

/* seg_bridge_top.f */
+incdir+include
logic/seg_bridge_pkg.sv
logic/sync_fifo.sv
logic/drain_ctrl.sv
logic/seg_convert.sv
logic/egress_align_check.sv
logic/seg_bridge_top.sv
tests/seg_bridge_chk.sv
tests/seg_bridge_mon.sv
tests/seg_bridge_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the bridge testbench with Verilator, runs it and scans the log for the fail message
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f seg_bridge_top.f \
    --top-module seg_bridge_tb \
    -o seg_bridge_sim

status=0
./obj_dir/seg_bridge_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Testbench failed" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation clean"
